/* compile.f */
core_pkg.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
hazard_unit.sv
execute_stage.sv
memory_stage.sv
riscv_core.sv
tb_riscv_core_asserts.sv
tb_riscv_core.sv

/* tb_riscv_core.sv */
/*
  Directed tests; each one resets the core, loads a program and checks the result port.
  Every program ends in BEQ x0,x0,0; words past it are left over from earlier tests.
*/
`timescale 1ns/1ns

module tb_riscv_core;
    import core_pkg::*;

    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;
    localparam int TIMEOUT_CYCLES  = NUM_TESTS * CYCLES_PER_TEST;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [6:0] F7_SUB = 7'b0100000;
    // BEQ x0,x0,0
    localparam instr_t SELF_LOOP = 32'h0000_0063;

    logic        clock;
    logic        reset;
    logic        start;
    imem_write_t imem_write;
    result_t     result;

    instr_t      program_words [$];
    logic [31:0] lfsr_state = 32'h7221;
    int          cycle_count = 0;

    riscv_core u_dut (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .imem_write (imem_write),
        .result     (result)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: no end of tests after %0d cycles", cycle_count);
            abort_run();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Encoding, ISA helpers and random immediates
    ////////////////////////////////////////////////////////////////////////////

    function automatic instr_t enc_r(reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2,
                                     logic [2:0] f3, logic [6:0] f7);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instr_t enc_i(logic [6:0] opc, logic [2:0] f3, reg_idx_t rd,
                                     reg_idx_t rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic instr_t enc_s(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic instr_t enc_b(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                     logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic instr_t addi(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
        return enc_i(OPC_OP_IMM, F3_ADD, rd, rs1, imm);
    endfunction

    function automatic word_t sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [11:0] random_imm();
        logic [11:0] bits;
        bits = '0;
        for (int i = 0; i < 12; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[10:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Harness tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "Stopping after the first failure");
    endtask

    // Inputs change 1 ns after the edge, outputs are read there too
    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        next_cycle();
        next_cycle();
        reset = 1'b0;
    endtask

    task automatic write_program();
        for (int i = 0; i < program_words.size(); i++) begin
            imem_write = '{valid: 1'b1, addr: IMEM_ADDR_BITS'(i), data: program_words[i]};
            next_cycle();
        end
        imem_write = '0;
    endtask

    task automatic load_program();
        write_program();
        start = 1'b1;
        next_cycle();
        start = 1'b0;
    endtask

    task automatic check_result(input result_t actual, input result_t expected);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: expected x%0d = %h, got valid %b x%0d = %h",
                     $time, expected.rd, expected.value, actual.valid, actual.rd, actual.value);
            abort_run();
        end
    endtask

    task automatic check_no_result(input result_t actual);
        if (actual.valid !== 1'b0) begin
            $display("ERROR at %0t ns: unexpected result x%0d = %h",
                     $time, actual.rd, actual.value);
            abort_run();
        end
    endtask

    task automatic expect_result(input reg_idx_t rd, input word_t value);
        next_cycle();
        while (result.valid !== 1'b1) begin
            next_cycle();
        end
        check_result(result, '{valid: 1'b1, rd: rd, value: value});
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            next_cycle();
            check_no_result(result);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_idle_after_reset();
        apply_reset();
        program_words = '{addi(18, 0, 12'd1), SELF_LOOP};
        write_program();
        check_idle(20);
    endtask

    task automatic test_alu_forwarding();
        word_t       x [REG_COUNT];
        logic [11:0] imm_a;
        logic [11:0] imm_b;
        imm_a = random_imm();
        imm_b = random_imm();
        x[18] = sext12(imm_a);
        x[19] = x[18] + sext12(imm_b);
        x[20] = x[19] + x[18];
        x[21] = x[18] - x[20];
        x[22] = x[21] & x[19];
        x[23] = x[22] | x[20];
        x[24] = x[23] ^ x[21];
        x[9]  = sext12(-12'sd5);
        x[25] = word_t'($signed(x[9]) < $signed(x[24]));
        program_words = '{addi(18, 0, imm_a), addi(19, 18, imm_b),
                          enc_r(20, 19, 18, F3_ADD, 7'd0), enc_r(21, 18, 20, F3_ADD, F7_SUB),
                          enc_r(22, 21, 19, F3_AND, 7'd0), enc_r(23, 22, 20, F3_OR, 7'd0),
                          enc_r(24, 23, 21, F3_XOR, 7'd0), addi(9, 0, -12'sd5),
                          enc_r(25, 9, 24, F3_SLT, 7'd0), enc_i(OPC_OP_IMM, F3_SLT, 18, 9, 12'd3),
                          enc_r(19, 24, 9, F3_SLT, 7'd0),
                          enc_i(OPC_OP_IMM, F3_XOR, 20, 25, imm_b),
                          enc_i(OPC_OP_IMM, F3_OR, 21, 20, imm_a),
                          enc_i(OPC_OP_IMM, F3_AND, 22, 21, 12'h7f0), SELF_LOOP};
        apply_reset();
        load_program();
        for (int r = 18; r <= 24; r++) begin
            expect_result(reg_idx_t'(r), x[r]);
        end
        expect_result(9, x[9]);
        expect_result(25, x[25]);
        // Second pass over x18..x22 with the immediate forms
        x[18] = word_t'($signed(x[9]) < $signed(sext12(12'd3)));
        x[19] = word_t'($signed(x[24]) < $signed(x[9]));
        x[20] = x[25] ^ sext12(imm_b);
        x[21] = x[20] | sext12(imm_a);
        x[22] = x[21] & sext12(12'h7f0);
        for (int r = 18; r <= 22; r++) begin
            expect_result(reg_idx_t'(r), x[r]);
        end
    endtask

    task automatic test_load_use();
        word_t stored;
        stored = sext12(random_imm());
        program_words = '{addi(18, 0, stored[11:0]), enc_s(18, 0, 12'd8),
                          enc_i(OPC_LOAD, 3'b010, 19, 0, 12'd8),
                          enc_r(20, 19, 19, F3_ADD, 7'd0), SELF_LOOP};
        apply_reset();
        load_program();
        expect_result(18, stored);
        expect_result(19, stored);
        expect_result(20, stored + stored);
    endtask

    task automatic test_branch_flush();
        program_words = '{addi(18, 0, 12'd7), addi(19, 0, 12'd7),
                          enc_b(F3_BEQ, 18, 19, 13'd12), addi(21, 0, 12'd1), addi(22, 0, 12'd2),
                          addi(23, 0, 12'd3), enc_b(F3_BNE, 18, 19, 13'd12), addi(24, 0, 12'd4),
                          enc_b(F3_BNE, 18, 0, 13'd12), addi(21, 0, 12'd5), addi(22, 0, 12'd6),
                          enc_r(25, 23, 24, F3_ADD, 7'd0), SELF_LOOP};
        apply_reset();
        load_program();
        expect_result(18, 32'd7);
        expect_result(19, 32'd7);
        expect_result(23, 32'd3);
        expect_result(24, 32'd4);
        expect_result(25, 32'd7);
        check_idle(10);
    endtask

    task automatic test_register_filter();
        logic [11:0] imm;
        imm = random_imm();
        program_words = '{addi(5, 0, imm), addi(0, 0, 12'd55),
                          enc_r(9, 0, 5, F3_ADD, 7'd0), enc_r(18, 0, 0, F3_ADD, 7'd0), SELF_LOOP};
        apply_reset();
        load_program();
        expect_result(9, sext12(imm));
        expect_result(18, '0);
    endtask

    task automatic test_back_to_back();
        word_t       x [REG_COUNT];
        logic [11:0] imm;
        program_words.delete();
        for (int r = 18; r <= 25; r++) begin
            imm = random_imm();
            x[r] = sext12(imm);
            program_words.push_back(addi(reg_idx_t'(r), 0, imm));
        end
        program_words.push_back(SELF_LOOP);
        apply_reset();
        load_program();
        expect_result(18, x[18]);
        // One result per cycle with no gaps
        for (int r = 19; r <= 25; r++) begin
            next_cycle();
            check_result(result, '{valid: 1'b1, rd: reg_idx_t'(r), value: x[r]});
        end
        check_idle(20);
    endtask

    initial begin
        reset      = 1'b1;
        start      = 1'b0;
        imem_write = '0;
        test_idle_after_reset();
        test_alu_forwarding();
        test_load_use();
        test_branch_flush();
        test_register_filter();
        test_back_to_back();
        if (u_dut.u_asserts.assertion_failures == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Assertion failures in the core: %0d", u_dut.u_asserts.assertion_failures);
            abort_run();
        end
    end

endmodule

/* tb_riscv_core_asserts.sv */
/*
  Bound into riscv_core; all checks but the reset one are off while reset is high.
*/
`timescale 1ns/1ns

module tb_riscv_core_asserts (
    input logic              clock,
    input logic              reset,
    input logic              stall,
    input logic              flush,
    input core_pkg::result_t result
);
    import core_pkg::*;

    int unsigned assertion_failures = 0;

    // A load and a branch never share ID/EX
    stall_flush_exclusive: assert property (
        @(posedge clock) disable iff (reset) !(stall && flush)
    ) else begin
        $error("stall and flush are active in the same cycle");
        assertion_failures++;
    end

    result_clear_after_reset: assert property (
        @(posedge clock) reset |=> !result.valid
    ) else begin
        $error("result.valid is high in the cycle after reset");
        assertion_failures++;
    end

    result_rd_reportable: assert property (
        @(posedge clock) disable iff (reset)
        result.valid |-> (result.rd == RESULT_REG_SAVED
                          || (result.rd >= RESULT_REG_LOW && result.rd <= RESULT_REG_HIGH))
    ) else begin
        $error("result strobe for register x%0d outside the reported set", result.rd);
        assertion_failures++;
    end

endmodule

bind riscv_core tb_riscv_core_asserts u_asserts (
    .clock  (clock),
    .reset  (reset),
    .stall  (stall),
    .flush  (flush),
    .result (result)
);

/* riscv_core.sv */
/*
  Five-stage RV32I subset core; load the program through imem_write, then strobe start.
  Branches are predicted not taken; a taken branch squashes two instructions.
*/
`timescale 1ns/1ns

module riscv_core (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start,
    input  core_pkg::imem_write_t imem_write,
    output core_pkg::result_t     result
);
    import core_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    wb_write_t wb;
    redirect_t redirect;
    logic      stall;
    logic      flush;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;

    fetch_stage u_fetch (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .imem_write (imem_write),
        .stall      (stall),
        .flush      (flush),
        .redirect   (redirect),
        .if_id      (if_id)
    );

    decode_stage u_decode (
        .clock (clock),
        .reset (reset),
        .if_id (if_id),
        .wb    (wb),
        .stall (stall),
        .flush (flush),
        .id_ex (id_ex)
    );

    execute_stage u_execute (
        .clock    (clock),
        .reset    (reset),
        .id_ex    (id_ex),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b),
        .ex_mem   (ex_mem),
        .wb       (wb),
        .redirect (redirect)
    );

    memory_stage u_memory (
        .clock  (clock),
        .reset  (reset),
        .ex_mem (ex_mem),
        .wb     (wb),
        .result (result)
    );

    hazard_unit u_hazard (
        .if_id    (if_id),
        .id_ex    (id_ex),
        .ex_mem   (ex_mem),
        .wb       (wb),
        .redirect (redirect),
        .stall    (stall),
        .flush    (flush),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b)
    );

endmodule

/* memory_stage.sv */
/*
  Word-only data memory, DMEM_DEPTH words, upper address bits ignored.
  The result strobe lags the register write by one cycle.
*/
`timescale 1ns/1ns

module memory_stage (
    input  logic                clock,
    input  logic                reset,
    input  core_pkg::ex_mem_t   ex_mem,
    output core_pkg::wb_write_t wb,
    output core_pkg::result_t   result
);
    import core_pkg::*;

    word_t                     dmem [DMEM_DEPTH];
    logic [DMEM_ADDR_BITS-1:0] word_addr;
    word_t                     load_data;
    logic                      reportable;

    assign word_addr = ex_mem.alu_result[DMEM_ADDR_BITS+1:2];
    assign load_data = dmem[word_addr];

    always_ff @(posedge clock) begin
        if (ex_mem.mem_write) begin
            dmem[word_addr] <= ex_mem.store_data;
        end
    end

    // MEM/WB holds the selected writeback value
    always_ff @(posedge clock) begin
        if (reset) begin
            wb <= '0;
        end else begin
            wb.enable <= ex_mem.reg_write;
            wb.rd     <= ex_mem.rd;
            wb.data   <= ex_mem.mem_read ? load_data : ex_mem.alu_result;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Result port, x9 and x18..x25 only
    ////////////////////////////////////////////////////////////////////////////

    assign reportable = (wb.rd == RESULT_REG_SAVED)
                        || (wb.rd >= RESULT_REG_LOW && wb.rd <= RESULT_REG_HIGH);

    always_ff @(posedge clock) begin
        if (reset) begin
            result <= '0;
        end else begin
            result.valid <= wb.enable && reportable;
            result.rd    <= wb.rd;
            result.value <= wb.data;
        end
    end

endmodule

/* execute_stage.sv */
/*
  Branches resolve here and redirect fetch combinationally.
  SLT compares signed; store data is the forwarded rs2 value.
*/
`timescale 1ns/1ns

module execute_stage (
    input  logic                clock,
    input  logic                reset,
    input  core_pkg::id_ex_t    id_ex,
    input  core_pkg::fwd_sel_e  fwd_a,
    input  core_pkg::fwd_sel_e  fwd_b,
    output core_pkg::ex_mem_t   ex_mem,
    input  core_pkg::wb_write_t wb,
    output core_pkg::redirect_t redirect
);
    import core_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t alu_b;
    word_t alu_y;

    function automatic word_t forward(fwd_sel_e sel, word_t reg_val,
                                      word_t ex_val, word_t wb_val);
        case (sel)
            FWD_EX_MEM: return ex_val;
            FWD_MEM_WB: return wb_val;
            default:    return reg_val;
        endcase
    endfunction

    assign op_a  = forward(fwd_a, id_ex.rs1_data, ex_mem.alu_result, wb.data);
    assign op_b  = forward(fwd_b, id_ex.rs2_data, ex_mem.alu_result, wb.data);
    assign alu_b = id_ex.ctrl.use_imm ? id_ex.imm : op_b;

    ////////////////////////////////////////////////////////////////////////////
    // ALU and branch compare
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_SUB: alu_y = op_a - alu_b;
            ALU_AND: alu_y = op_a & alu_b;
            ALU_OR:  alu_y = op_a | alu_b;
            ALU_XOR: alu_y = op_a ^ alu_b;
            ALU_SLT: alu_y = word_t'($signed(op_a) < $signed(alu_b));
            default: alu_y = op_a + alu_b;
        endcase
    end

    // BNE inverts the equality
    assign redirect.taken  = id_ex.ctrl.branch && ((op_a == op_b) != id_ex.ctrl.branch_ne);
    assign redirect.target = id_ex.pc + id_ex.imm[PC_BITS-1:0];

    always_ff @(posedge clock) begin
        if (reset) begin
            ex_mem <= '0;
        end else begin
            ex_mem.reg_write  <= id_ex.ctrl.reg_write;
            ex_mem.mem_read   <= id_ex.ctrl.mem_read;
            ex_mem.mem_write  <= id_ex.ctrl.mem_write;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.alu_result <= alu_y;
            ex_mem.store_data <= op_b;
        end
    end

endmodule

/* hazard_unit.sv */
/*
  Load-use stall, branch flush and forwarding selects, all combinational.
  EX/MEM wins over MEM/WB; a load and a branch never share ID/EX, so stall and flush never meet.
*/
`timescale 1ns/1ns

module hazard_unit (
    input  core_pkg::if_id_t    if_id,
    input  core_pkg::id_ex_t    id_ex,
    input  core_pkg::ex_mem_t   ex_mem,
    input  core_pkg::wb_write_t wb,
    input  core_pkg::redirect_t redirect,
    output logic                stall,
    output logic                flush,
    output core_pkg::fwd_sel_e  fwd_a,
    output core_pkg::fwd_sel_e  fwd_b
);
    import core_pkg::*;

    logic [6:0] opcode;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    logic       uses_rs2;

    function automatic fwd_sel_e select_source(reg_idx_t src);
        if (ex_mem.reg_write && ex_mem.rd != '0 && ex_mem.rd == src) begin
            return FWD_EX_MEM;
        end else if (wb.enable && wb.rd != '0 && wb.rd == src) begin
            return FWD_MEM_WB;
        end
        return FWD_REG;
    endfunction

    assign opcode   = if_id.instr[6:0];
    assign rs1      = if_id.instr[19:15];
    assign rs2      = if_id.instr[24:20];
    // I-type immediates overlap rs2 and must not cause a stall
    assign uses_rs2 = (opcode == OPC_OP) || (opcode == OPC_STORE) || (opcode == OPC_BRANCH);

    assign flush = redirect.taken;
    assign stall = if_id.valid && id_ex.ctrl.mem_read && id_ex.rd != '0
                   && (id_ex.rd == rs1 || (uses_rs2 && id_ex.rd == rs2));

    assign fwd_a = select_source(id_ex.rs1);
    assign fwd_b = select_source(id_ex.rs2);

endmodule

/* decode_stage.sv */
/*
  Unsupported encodings and invalid slots decode as bubbles.
  Stall and flush both load a bubble into ID/EX.
*/
`timescale 1ns/1ns

module decode_stage (
    input  logic                clock,
    input  logic                reset,
    input  core_pkg::if_id_t    if_id,
    input  core_pkg::wb_write_t wb,
    input  logic                stall,
    input  logic                flush,
    output core_pkg::id_ex_t    id_ex
);
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      imm;
    ctrl_t      ctrl;
    logic       known;

    assign opcode = if_id.instr[6:0];
    assign rd     = if_id.instr[11:7];
    assign funct3 = if_id.instr[14:12];
    assign rs1    = if_id.instr[19:15];
    assign rs2    = if_id.instr[24:20];
    assign funct7 = if_id.instr[31:25];

    register_file u_register_file (
        .clock    (clock),
        .reset    (reset),
        .rs1      (rs1),
        .rs2      (rs2),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Control and immediate
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        ctrl  = '0;
        known = 1'b1;
        imm   = {{20{if_id.instr[31]}}, if_id.instr[31:20]};
        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = (opcode == OPC_OP_IMM);
                case (funct3)
                    3'b000: ctrl.alu_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
                    3'b010: ctrl.alu_op = ALU_SLT;
                    3'b100: ctrl.alu_op = ALU_XOR;
                    3'b110: ctrl.alu_op = ALU_OR;
                    3'b111: ctrl.alu_op = ALU_AND;
                    default: known = 1'b0;
                endcase
            end
            OPC_LOAD: begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.use_imm   = 1'b1;
                known          = (funct3 == 3'b010);
            end
            OPC_STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                known          = (funct3 == 3'b010);
                imm = {{20{if_id.instr[31]}}, if_id.instr[31:25], if_id.instr[11:7]};
            end
            OPC_BRANCH: begin
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = funct3[0];
                known          = (funct3[2:1] == 2'b00);
                imm = {{19{if_id.instr[31]}}, if_id.instr[31], if_id.instr[7],
                       if_id.instr[30:25], if_id.instr[11:8], 1'b0};
            end
            default: known = 1'b0;
        endcase
        if (!known || !if_id.valid) begin
            ctrl = '0;
        end
    end

    // ID/EX register
    always_ff @(posedge clock) begin
        if (reset || stall || flush) begin
            id_ex <= '0;
        end else begin
            id_ex <= '{ctrl: ctrl, pc: if_id.pc, rs1: rs1, rs2: rs2, rd: rd,
                       rs1_data: rs1_data, rs2_data: rs2_data, imm: imm};
        end
    end

endmodule

/* register_file.sv */
/*
  x0 reads as zero; a read of the register written this cycle sees the new value.
*/
`timescale 1ns/1ns

module register_file (
    input  logic                clock,
    input  logic                reset,
    input  core_pkg::reg_idx_t  rs1,
    input  core_pkg::reg_idx_t  rs2,
    input  core_pkg::wb_write_t wb,
    output core_pkg::word_t     rs1_data,
    output core_pkg::word_t     rs2_data
);
    import core_pkg::*;

    word_t regs [REG_COUNT];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.enable && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Write-through bypass
    assign rs1_data = (wb.enable && wb.rd != '0 && wb.rd == rs1) ? wb.data : regs[rs1];
    assign rs2_data = (wb.enable && wb.rd != '0 && wb.rd == rs2) ? wb.data : regs[rs2];

endmodule

/* fetch_stage.sv */
/*
  Instruction memory accepts writes only before start; only reset stops the core.
  Fetch begins at pc 0 in the cycle after the start strobe.
*/
`timescale 1ns/1ns

module fetch_stage (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start,
    input  core_pkg::imem_write_t imem_write,
    input  logic                  stall,
    input  logic                  flush,
    input  core_pkg::redirect_t   redirect,
    output core_pkg::if_id_t      if_id
);
    import core_pkg::*;

    logic   running;
    pc_t    pc;
    instr_t imem [IMEM_DEPTH];

    always_ff @(posedge clock) begin
        if (reset) begin
            running <= 1'b0;
        end else if (start) begin
            running <= 1'b1;
        end
    end

    // Program load port
    always_ff @(posedge clock) begin
        if (!running && imem_write.valid) begin
            imem[imem_write.addr] <= imem_write.data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else if (flush) begin
            pc <= redirect.target;
        end else if (running && !stall) begin
            pc <= pc + pc_t'(4);
        end
    end

    // IF/ID, a NOP while idle or squashed
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            if_id <= '{instr: NOP_INSTR, pc: '0, valid: 1'b0};
        end else if (!stall) begin
            if_id.instr <= running ? imem[pc[IMEM_ADDR_BITS+1:2]] : NOP_INSTR;
            if_id.pc    <= pc;
            if_id.valid <= running;
        end
    end

endmodule

/* core_pkg.sv */
/*
  Shared sizes, encodings and pipeline structs for the RV32I subset core.
  Memories are word-addressed and small; PC_BITS limits programs to IMEM_DEPTH words.
*/
package core_pkg;

    // Sizes
    localparam int XLEN           = 32;
    localparam int REG_COUNT      = 32;
    localparam int IMEM_DEPTH     = 64;
    localparam int DMEM_DEPTH     = 64;
    localparam int IMEM_ADDR_BITS = $clog2(IMEM_DEPTH);
    localparam int DMEM_ADDR_BITS = $clog2(DMEM_DEPTH);
    localparam int PC_BITS        = 8;

    typedef logic [XLEN-1:0]    word_t;
    typedef logic [31:0]        instr_t;
    typedef logic [4:0]         reg_idx_t;
    typedef logic [PC_BITS-1:0] pc_t;

    // ADDI x0,x0,0
    localparam instr_t NOP_INSTR = 32'h0000_0013;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // Writes to these registers show up on the result port
    localparam reg_idx_t RESULT_REG_LOW   = 5'd18;
    localparam reg_idx_t RESULT_REG_HIGH  = 5'd25;
    localparam reg_idx_t RESULT_REG_SAVED = 5'd9;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REG, FWD_EX_MEM, FWD_MEM_WB
    } fwd_sel_e;

    // All zero is a bubble
    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    branch_ne;
        logic    use_imm;
        alu_op_e alu_op;
    } ctrl_t;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline registers
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        instr_t instr;
        pc_t    pc;
        logic   valid;
    } if_id_t;

    typedef struct packed {
        ctrl_t    ctrl;
        pc_t      pc;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    rs1_data;
        word_t    rs2_data;
        word_t    imm;
    } id_ex_t;

    typedef struct packed {
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        reg_idx_t rd;
        word_t    alu_result;
        word_t    store_data;
    } ex_mem_t;

    ////////////////////////////////////////////////////////////////////////////
    // Ports
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic     enable;
        reg_idx_t rd;
        word_t    data;
    } wb_write_t;

    typedef struct packed {
        logic taken;
        pc_t  target;
    } redirect_t;

    typedef struct packed {
        logic                      valid;
        logic [IMEM_ADDR_BITS-1:0] addr;
        instr_t                    data;
    } imem_write_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    value;
    } result_t;

endpackage
